/* rtl/rv_defines.svh */
// Global size macros for the single-cycle core, included by RTL and testbench sources
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path and address width
`define XLEN 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// Instruction memory depth in 32-bit words
`define IMEM_WORDS 256

// Data memory depth in 32-bit words
`define DMEM_WORDS 256

`endif

/* rtl/rvIsaPkg.sv */
// Instruction-set encodings of the supported RV32I subset, shared by decode logic and testbench
package rvIsaPkg;

    // Major opcodes, bits 6:0 of the instruction word
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011, // LW
        OPC_ITYPE  = 7'b0010011, // ADDI, ANDI, ORI, XORI, SLTI
        OPC_STORE  = 7'b0100011, // SW
        OPC_RTYPE  = 7'b0110011, // ADD, SUB, AND, OR, XOR, SLT, SLL, SRL
        OPC_BRANCH = 7'b1100011  // BEQ
    } opcodeE;

    // Arithmetic funct3, bits 14:12
    typedef enum logic [2:0] {
        F3_ADDSUB = 3'b000, // ADD/SUB split by funct7 bit 5
        F3_SLL    = 3'b001,
        F3_SLT    = 3'b010, // Signed compare
        F3_XOR    = 3'b100,
        F3_SRL    = 3'b101, // Logical only, SRA not supported
        F3_OR     = 3'b110,
        F3_AND    = 3'b111
    } funct3E;

endpackage

/* rtl/cpuCtrlPkg.sv */
// Internal control encodings passed between the decoder and the execute stage
package cpuCtrlPkg;

    // Operation class chosen by the main decoder
    typedef enum logic [1:0] {
        ALUOP_MEM    = 2'b00, // Address calculation, always add
        ALUOP_BRANCH = 2'b01, // Compare for BEQ, always subtract
        ALUOP_RTYPE  = 2'b10, // Function from funct3 and funct7
        ALUOP_ITYPE  = 2'b11  // Function from funct3 only
    } aluOpE;

    // Function actually performed by the ALU
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } aluSelE;

endpackage

/* rtl/cpuIfs.sv */
// Interfaces for the decoder control bundle and the data-memory port inside the core
`include "rv_defines.svh"

interface ctrlIf import cpuCtrlPkg::*; ();
    logic  branch;   // Conditional branch instruction
    logic  memRead;  // Load from data memory
    logic  memToReg; // Write-back from memory instead of ALU
    aluOpE aluOp;    // Operation class for ALU decode
    logic  memWrite; // Store to data memory
    logic  aluSrc;   // Second operand is the immediate
    logic  regWrite; // Register file write

    // Main decoder side
    modport decoder (output branch, memRead, memToReg, aluOp, memWrite, aluSrc, regWrite);
    // ALU only needs the class and operand select
    modport execute (input aluOp, aluSrc);
    // Top-level glue uses the rest
    modport datapath (input branch, memRead, memToReg, memWrite, regWrite);
endinterface

interface memIf ();
    logic [`XLEN-1:0] addr;  // Byte address
    logic [`XLEN-1:0] wdata; // Store data
    logic [`XLEN-1:0] rdata; // Load data, zero when not reading
    logic             read;  // Read enable
    logic             write; // Write strobe, sampled at rising clk

    modport master (output addr, wdata, read, write, input rdata);
    modport memory (input addr, wdata, read, write, output rdata);
endinterface

/* rtl/controlUnit.sv */
// Main opcode decoder producing the control bundle for one instruction per cycle
module controlUnit import rvIsaPkg::*; import cpuCtrlPkg::*; (
    input  opcodeE        opcode, // Bits 6:0 of the current instruction
    ctrlIf.decoder        ctrl    // Control bundle to datapath and ALU
);

    always_comb begin
        // Everything off unless the opcode is recognised
        ctrl.branch   = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.aluOp    = ALUOP_MEM;
        ctrl.memWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.regWrite = 1'b0;

        case (opcode)
            OPC_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALUOP_RTYPE; // Both operands from registers
            end

            OPC_ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;        // rs1 op immediate
                ctrl.aluOp    = ALUOP_ITYPE;
            end

            // LW, address is rs1 plus I-immediate
            OPC_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;        // Load data to rd
                ctrl.memRead  = 1'b1;
                ctrl.aluOp    = ALUOP_MEM;
            end

            // SW, no register write
            OPC_STORE: begin
                ctrl.aluSrc   = 1'b1;        // S-immediate offset
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = ALUOP_MEM;
            end

            // BEQ, compare rs1 and rs2 by subtraction
            OPC_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.aluSrc   = 1'b0;
                ctrl.aluOp    = ALUOP_BRANCH;
            end

            default: begin
                // Unsupported opcode behaves as a no-op
            end
        endcase
    end

endmodule

/* rtl/aluUnit.sv */
// ALU function decode and arithmetic/logic unit with zero flag for the execute step
`include "rv_defines.svh"

module aluUnit import rvIsaPkg::*; import cpuCtrlPkg::*; (
    ctrlIf.execute           ctrl,     // aluOp and aluSrc from the decoder
    input  logic [2:0]       funct3,   // Instruction bits 14:12
    input  logic             funct7b5, // Instruction bit 30
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] imm,      // Sign-extended immediate
    output logic [`XLEN-1:0] result,
    output logic             zero      // Result is all zeros, used by BEQ
);

    aluSelE           aluSel;
    logic [`XLEN-1:0] opB;

    // Class plus funct fields to ALU function
    always_comb begin
        case (ctrl.aluOp)
            ALUOP_MEM:    aluSel = ALU_ADD;
            ALUOP_BRANCH: aluSel = ALU_SUB;
            default: begin
                // R-type and I-type share the funct3 map
                case (funct3E'(funct3))
                    F3_ADDSUB: begin
                        // Bit 30 of an I-type is immediate data, not SUB
                        if (ctrl.aluOp == ALUOP_RTYPE && funct7b5) aluSel = ALU_SUB;
                        else aluSel = ALU_ADD;
                    end
                    F3_SLL:  aluSel = ALU_SLL;
                    F3_SLT:  aluSel = ALU_SLT;
                    F3_XOR:  aluSel = ALU_XOR;
                    F3_SRL:  aluSel = ALU_SRL;
                    F3_OR:   aluSel = ALU_OR;
                    F3_AND:  aluSel = ALU_AND;
                    default: aluSel = ALU_ADD; // SLTU not in the subset
                endcase
            end
        endcase
    end

    assign opB = ctrl.aluSrc ? imm : rs2Data; // Immediate or register operand

    always_comb begin
        case (aluSel)
            ALU_ADD: result = rs1Data + opB;
            ALU_SUB: result = rs1Data - opB;
            ALU_AND: result = rs1Data & opB;
            ALU_OR:  result = rs1Data | opB;
            ALU_XOR: result = rs1Data ^ opB;
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(rs1Data) < $signed(opB)};
            ALU_SLL: result = rs1Data << opB[4:0]; // Only low 5 bits shift
            ALU_SRL: result = rs1Data >> opB[4:0];
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* rtl/regFile.sv */
// Integer register file with two combinational read ports and one clocked write port
`include "rv_defines.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    input  logic [4:0]       rdAddr,
    input  logic             we,      // Write rd at the rising clk
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0; // All registers start at zero
            end
        end else if (we && rdAddr != 5'd0) begin
            regs[rdAddr] <= wdata; // x0 writes dropped
        end
    end

    // x0 is hardwired regardless of array contents
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

/* rtl/immGen.sv */
// Immediate extraction and sign extension for the I, S and B instruction formats
`include "rv_defines.svh"

module immGen import rvIsaPkg::*; (
    input  logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] imm
);

    always_comb begin
        case (opcodeE'(instr[6:0]))
            // I-format, bits 31:20
            OPC_ITYPE, OPC_LOAD: imm = {{20{instr[31]}}, instr[31:20]};
            // S-format, split across 31:25 and 11:7
            OPC_STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // B-format, halfword offset with implied zero LSB
            OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            default: imm = '0; // R-type and unknown carry no immediate
        endcase
    end

endmodule

/* rtl/fetchUnit.sv */
// Program counter and instruction memory with a load port used while the core is held in reset
`include "rv_defines.svh"

module fetchUnit (
    input  logic             clk,
    input  logic             rstN,
    input  logic             branchTaken, // BEQ with equal operands
    input  logic [`XLEN-1:0] branchImm,   // B-immediate, byte offset
    input  logic             imemWe,      // Load strobe
    input  logic [7:0]       imemAddr,    // Word index for loading
    input  logic [`XLEN-1:0] imemWdata,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] instr        // Instruction at pc, same cycle
);

    logic [`XLEN-1:0] imem [`IMEM_WORDS];

    // Next pc, branch target or sequential
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0; // Fetch starts at address 0
        end else if (branchTaken) begin
            pc <= pc + branchImm;
        end else begin
            pc <= pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (imemWe) imem[imemAddr] <= imemWdata; // Program load
    end

    assign instr = imem[pc[9:2]]; // Word aligned, upper pc bits ignored

endmodule

/* rtl/dataMem.sv */
// Word-addressed data memory with combinational read and clocked write
`include "rv_defines.svh"

module dataMem (
    input  logic clk,
    memIf.memory bus // Address, data and strobes from the core
);

    localparam int DmemAw = $clog2(`DMEM_WORDS); // Word index width

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [DmemAw-1:0] wordIdx;

    assign wordIdx = bus.addr[DmemAw+1:2]; // Byte offset and high bits dropped

    always_ff @(posedge clk) begin
        if (bus.write) mem[wordIdx] <= bus.wdata;
    end

    // Read data only while a load is active
    assign bus.rdata = bus.read ? mem[wordIdx] : '0;

endmodule

/* rtl/cpuTop.sv */
// Top level of the single-cycle core, wiring all blocks and exposing load and retire ports
`include "rv_defines.svh"

module cpuTop import rvIsaPkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  logic             imemWe,        // Program load, used while rstN is low
    input  logic [7:0]       imemAddr,
    input  logic [`XLEN-1:0] imemWdata,
    output logic [`XLEN-1:0] pc,
    output logic             retireRegWe,   // Register write of the current instruction
    output logic [4:0]       retireRd,
    output logic [`XLEN-1:0] retireRegData,
    output logic             retireMemWe,   // Store of the current instruction
    output logic [`XLEN-1:0] retireMemAddr,
    output logic [`XLEN-1:0] retireMemData
);

    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] aluResult;
    logic             aluZero;
    logic [`XLEN-1:0] wbData;      // Write-back value
    logic             branchTaken;
    logic             regWe;       // Register write, held off in reset

    ctrlIf ctrl ();
    memIf  dBus ();

    fetchUnit uFetch (.clk, .rstN, .branchTaken, .branchImm(imm), .imemWe, .imemAddr,
                      .imemWdata, .pc, .instr);

    controlUnit uCtrl (.opcode(opcodeE'(instr[6:0])), .ctrl(ctrl.decoder));

    immGen uImm (.instr, .imm);

    regFile uRegs (.clk, .rstN, .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
                   .rdAddr(instr[11:7]), .we(regWe), .wdata(wbData), .rs1Data, .rs2Data);

    aluUnit uAlu (.ctrl(ctrl.execute), .funct3(instr[14:12]), .funct7b5(instr[30]),
                  .rs1Data, .rs2Data, .imm, .result(aluResult), .zero(aluZero));

    // Data memory port
    assign dBus.addr  = aluResult;             // rs1 plus offset
    assign dBus.wdata = rs2Data;
    assign dBus.read  = ctrl.memRead;
    assign dBus.write = ctrl.memWrite & rstN;  // No stores while loading

    dataMem uDmem (.clk, .bus(dBus.memory));

    assign wbData      = ctrl.memToReg ? dBus.rdata : aluResult;
    assign branchTaken = ctrl.branch & aluZero; // BEQ taken when rs1 - rs2 is zero
    assign regWe       = ctrl.regWrite & rstN;

    // Retire view of the instruction at pc
    assign retireRegWe   = regWe;
    assign retireRd      = instr[11:7];
    assign retireRegData = wbData;
    assign retireMemWe   = dBus.write;
    assign retireMemAddr = aluResult;
    assign retireMemData = rs2Data;

endmodule

/* tests/cpuTb.sv */
// Self-checking testbench for the core, runs a random program against a reference model
`include "rv_defines.svh"

module cpuTb import rvIsaPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // Instruction kinds known to the generator and model
    typedef enum int {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL,
        ADDI, ANDI, ORI, XORI, SLTI, LW, SW, BEQ
    } kindE;

    logic             clk = 1'b0;
    logic             rstN;
    logic             imemWe;
    logic [7:0]       imemAddr;
    logic [`XLEN-1:0] imemWdata;
    logic [`XLEN-1:0] pc;
    logic             retireRegWe;
    logic [4:0]       retireRd;
    logic [`XLEN-1:0] retireRegData;
    logic             retireMemWe;
    logic [`XLEN-1:0] retireMemAddr;
    logic [`XLEN-1:0] retireMemData;

    // Program image plus what each word is meant to do
    logic [`XLEN-1:0] progWord [`IMEM_WORDS];
    kindE             progKind [`IMEM_WORDS];
    logic [4:0]       progRd [`IMEM_WORDS];
    logic [4:0]       progRs1 [`IMEM_WORDS];
    logic [4:0]       progRs2 [`IMEM_WORDS];
    logic [`XLEN-1:0] progImm [`IMEM_WORDS]; // Already sign-extended
    int               progLen;
    logic [`XLEN-1:0] endPc;                 // Address of BEQ x0,x0,0

    // Reference model state and its prediction for the current pc
    logic [`XLEN-1:0] mReg [`REG_COUNT];
    logic [`XLEN-1:0] mMem [`DMEM_WORDS];
    logic [`XLEN-1:0] mPc;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] expPc;
    logic             expRegWe;
    logic [4:0]       expRd;
    logic [`XLEN-1:0] expRegData;
    logic             expMemWe;
    logic [`XLEN-1:0] expMemAddr;
    logic [`XLEN-1:0] expMemData;
    string            testName = "RESET";
    int               seed = 94357;

    always #5 clk = ~clk; // 10 ns period

    cpuTop u_cpuTop (.clk, .rstN, .imemWe, .imemAddr, .imemWdata, .pc, .retireRegWe, .retireRd,
                     .retireRegData, .retireMemWe, .retireMemAddr, .retireMemData);

    task automatic reportMismatch(input string what, input logic [31:0] expV, actV);
        $display("MISMATCH %s %s: expected 0x%08h, actual 0x%08h", testName, what, expV, actV);
        $display("*** FAILED ***");
        $fatal(1, "Retire port disagrees with the reference model");
    endtask

    // Sampled at each rising edge, model values are stable there
    pcMatch: assert property (@(posedge clk) pc == expPc)
        else reportMismatch("pc", expPc, $sampled(pc));
    regWeMatch: assert property (@(posedge clk) retireRegWe == expRegWe)
        else reportMismatch("regWe", 32'(expRegWe), 32'($sampled(retireRegWe)));
    rdMatch: assert property (@(posedge clk) expRegWe |-> retireRd == expRd)
        else reportMismatch("rd", 32'(expRd), 32'($sampled(retireRd)));
    regDataMatch: assert property (@(posedge clk) expRegWe |-> retireRegData == expRegData)
        else reportMismatch("regData", expRegData, $sampled(retireRegData));
    memWeMatch: assert property (@(posedge clk) retireMemWe == expMemWe)
        else reportMismatch("memWe", 32'(expMemWe), 32'($sampled(retireMemWe)));
    memAddrMatch: assert property (@(posedge clk) expMemWe |-> retireMemAddr == expMemAddr)
        else reportMismatch("memAddr", expMemAddr, $sampled(retireMemAddr));
    memDataMatch: assert property (@(posedge clk) expMemWe |-> retireMemData == expMemData)
        else reportMismatch("memData", expMemData, $sampled(retireMemData));

    function automatic int randRange(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    function automatic logic [31:0] randImm12();
        logic [11:0] v;
        v = 12'($random(seed));
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [4:0] randDst();
        return 5'(randRange(14) + 1); // x1..x14, x15 kept as a base
    endfunction

    function automatic logic [4:0] randSrc();
        return 5'(randRange(16));
    endfunction

    // Encode one instruction and record its intent
    task automatic emit(input kindE k, input logic [4:0] rd, rs1, rs2, input logic [31:0] imm);
        logic [31:0] w;
        logic [6:0]  f7;
        logic [2:0]  f3;
        f7 = (k == SUB) ? 7'h20 : 7'h00; // SUB differs from ADD only here
        case (k)
            SLL:                 f3 = 3'd1;
            SLT, SLTI, LW, SW:   f3 = 3'd2;
            XOR, XORI:           f3 = 3'd4;
            SRL:                 f3 = 3'd5;
            OR, ORI:             f3 = 3'd6;
            AND, ANDI:           f3 = 3'd7;
            default:             f3 = 3'd0;
        endcase
        case (k)
            ADD, SUB, AND, OR, XOR, SLT, SLL, SRL: w = {f7, rs2, rs1, f3, rd, OPC_RTYPE};
            ADDI, ANDI, ORI, XORI, SLTI: w = {imm[11:0], rs1, f3, rd, OPC_ITYPE};
            LW: w = {imm[11:0], rs1, f3, rd, OPC_LOAD};
            SW: w = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
            default: w = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
        endcase
        progWord[progLen] = w;
        progKind[progLen] = k;
        progRd[progLen]   = rd;
        progRs1[progLen]  = rs1;
        progRs2[progLen]  = rs2;
        progImm[progLen]  = imm;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [31:0] off;
        progLen = 0;
        emit(ADDI, 5'd1, 5'd0, 5'd0, -32'sd1 - 32'(randRange(1000))); // Negative for SLT
        for (int r = 2; r <= 8; r++) emit(ADDI, 5'(r), 5'd0, 5'd0, randImm12());
        emit(SLT, 5'd9, 5'd1, 5'd2, '0);   // Signed compare, both orders
        emit(SLT, 5'd10, 5'd2, 5'd1, '0);
        emit(SUB, 5'd11, 5'd3, 5'd4, '0);
        emit(ADD, 5'd12, 5'd3, 5'd4, '0);
        for (int n = 0; n < 2; n++) begin
            for (int k = ADD; k <= SRL; k++) begin
                emit(kindE'(k), randDst(), randSrc(), randSrc(), '0);
            end
            for (int k = ADDI; k <= SLTI; k++) begin
                emit(kindE'(k), randDst(), randSrc(), 5'd0, randImm12());
            end
        end
        emit(ADD, 5'd0, 5'd3, 5'd4, '0);      // Writes to x0 are dropped
        emit(ADDI, 5'd0, 5'd0, 5'd0, 32'd123);
        emit(OR, 5'd13, 5'd0, 5'd0, '0);      // Reads x0 afterwards
        emit(ADDI, 5'd14, 5'd0, 5'd0, 32'd5);
        for (int n = 0; n < 3; n++) begin
            off = 32'(randRange(256) * 4);
            emit(SW, 5'd0, 5'd0, randSrc(), off);
            emit(LW, randDst(), 5'd0, 5'd0, off);
        end
        emit(ADDI, 5'd15, 5'd0, 5'd0, 32'd256); // Base register pair
        emit(SW, 5'd0, 5'd15, 5'd7, 32'd12);
        emit(LW, 5'd9, 5'd15, 5'd0, 32'd12);
        emit(BEQ, 5'd0, 5'd3, 5'd3, 32'd8);     // Always taken
        emit(ADDI, 5'd14, 5'd0, 5'd0, 32'd99);  // Skipped
        emit(ADDI, 5'd14, 5'd0, 5'd0, 32'd7);
        emit(BEQ, 5'd0, 5'd14, 5'd0, 32'd8);    // Never taken
        emit(ADDI, 5'd13, 5'd14, 5'd0, 32'd1);
        for (int n = 0; n < 4; n++) begin
            emit(BEQ, 5'd0, randSrc(), randSrc(), (randRange(2) == 0) ? 32'd8 : 32'd12);
            emit(ADDI, randDst(), randSrc(), 5'd0, randImm12());
            emit(XORI, randDst(), randSrc(), 5'd0, randImm12());
        end
        emit(BEQ, 5'd0, 5'd0, 5'd0, 32'd0);     // End marker
        endPc = 32'((progLen - 1) * 4);
    endtask

    // Expected retire values for the instruction at mPc
    task automatic predict();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        kindE        k;
        k          = progKind[mPc[9:2]];
        a          = mReg[progRs1[mPc[9:2]]];
        b          = mReg[progRs2[mPc[9:2]]];
        imm        = progImm[mPc[9:2]];
        testName   = k.name();
        expPc      = mPc;
        expRd      = progRd[mPc[9:2]];
        expRegWe   = 1'b1;
        expRegData = '0;
        expMemWe   = 1'b0;
        expMemAddr = a + imm;
        expMemData = b;
        nextPc     = mPc + 32'd4;
        case (k)
            ADD:  expRegData = a + b;
            SUB:  expRegData = a - b;
            AND:  expRegData = a & b;
            OR:   expRegData = a | b;
            XOR:  expRegData = a ^ b;
            SLT:  expRegData = {31'd0, $signed(a) < $signed(b)};
            SLL:  expRegData = a << b[4:0];
            SRL:  expRegData = a >> b[4:0];
            ADDI: expRegData = a + imm;
            ANDI: expRegData = a & imm;
            ORI:  expRegData = a | imm;
            XORI: expRegData = a ^ imm;
            SLTI: expRegData = {31'd0, $signed(a) < $signed(imm)};
            LW:   expRegData = mMem[expMemAddr[9:2]]; // Upper address bits wrap
            SW: begin
                expRegWe = 1'b0;
                expMemWe = 1'b1;
            end
            default: begin
                expRegWe = 1'b0;                  // BEQ writes nothing
                if (a == b) nextPc = mPc + imm;
            end
        endcase
    endtask

    task automatic commitModel();
        if (expRegWe && expRd != 5'd0) mReg[expRd] = expRegData; // x0 stays zero
        if (expMemWe) mMem[expMemAddr[9:2]] = expMemData;
        mPc = nextPc;
    endtask

    initial begin
        int loadCycles;
        int cycles;
        int seenEnd;
        rstN       = 1'b1;
        imemWe     = 1'b0;
        imemAddr   = '0;
        imemWdata  = '0;
        expPc      = '0;
        expRegWe   = 1'b0;
        expMemWe   = 1'b0;
        expRd      = '0;
        expRegData = '0;
        expMemAddr = '0;
        expMemData = '0;
        mPc        = '0;
        for (int r = 0; r < `REG_COUNT; r++) mReg[r] = '0;
        buildProgram();
        #1 rstN = 1'b0;
        // At least 10 reset cycles, more if the program is longer
        loadCycles = (progLen > 10) ? progLen : 10;
        for (int i = 0; i < loadCycles; i++) begin
            @(posedge clk);
            #1;
            imemWe    = (i < progLen);
            imemAddr  = 8'(i);
            imemWdata = progWord[i];
        end
        @(posedge clk);
        #1;
        imemWe = 1'b0;
        rstN   = 1'b1;
        predict();
        cycles  = 0;
        seenEnd = 0;
        while (seenEnd < 2 && cycles < 2000) begin
            @(posedge clk);
            #1;
            commitModel();
            predict();
            cycles++;
            if (pc == endPc) seenEnd++; // Self-branch must hold pc
        end
        if (seenEnd < 2) begin
            $display("Timeout: the end marker was not reached within 2000 cycles");
            $display("*** FAILED ***");
            $fatal(1, "Program did not finish");
        end else begin
            @(posedge clk);
            #1;
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* rvSingleCycle.f */
+incdir+rtl
rtl/rvIsaPkg.sv
rtl/cpuCtrlPkg.sv
rtl/cpuIfs.sv
rtl/controlUnit.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/immGen.sv
rtl/fetchUnit.sv
rtl/dataMem.sv
rtl/cpuTop.sv
tests/cpuTb.sv

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -f rvSingleCycle.f -o simCpu

output=$(./obj_dir/simCpu) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
